// File: verilog/usb_line_pkg.sv
/*
 * line level definitions for low-speed USB reception
 *   byte, payload index and byte count types
 *   sampled D+/D- line state encoding
 *   bit stuffing limit and packet framing constants
 */
package usb_line_pkg;

  typedef logic [7:0] usb_byte_t;  // one received byte
  typedef logic [2:0] byte_idx_t;  // payload byte number, 0 to 7
  typedef logic [3:0] byte_cnt_t;  // whole bytes seen in a packet, sync included

  // encoded as {D+, D-}; low speed idle J has D- high
  typedef enum logic [1:0] {
    LS_SE0 = 2'b00,  // both low, end of packet or no device
    LS_J   = 2'b01,  // D- high
    LS_K   = 2'b10,  // D+ high
    LS_SE1 = 2'b11   // illegal, ignored
  } line_state_e;

  localparam logic [2:0] STUFF_LIMIT = 3'd6;  // ones before a stuffed zero
  localparam byte_cnt_t  HDR_BYTES   = 4'd2;  // sync and pid, not delivered
  localparam byte_cnt_t  MAX_PAYLOAD = 4'd8;  // payload bytes delivered per packet

endpackage

// File: verilog/hid_report_pkg.sv
/*
 * HID report level definitions
 *   device type enum
 *   gamepad button word and its bit positions
 *   interface descriptor byte positions and class codes
 */
package hid_report_pkg;

  typedef enum logic [1:0] {
    HID_NONE     = 2'd0,  // nothing attached or not a HID device
    HID_KEYBOARD = 2'd1,
    HID_MOUSE    = 2'd2,
    HID_GAMEPAD  = 2'd3
  } hid_type_e;

  typedef logic [9:0] game_btn_t;  // see GB_* for bit order

  // gamepad button positions
  localparam int GB_LEFT   = 0;
  localparam int GB_RIGHT  = 1;
  localparam int GB_UP     = 2;
  localparam int GB_DOWN   = 3;
  localparam int GB_A      = 4;
  localparam int GB_B      = 5;
  localparam int GB_X      = 6;
  localparam int GB_Y      = 7;
  localparam int GB_SELECT = 8;
  localparam int GB_START  = 9;

  // payload positions of the interface descriptor fields
  localparam logic [2:0] IF_CLASS_POS    = 3'd5;
  localparam logic [2:0] IF_SUBCLASS_POS = 3'd6;
  localparam logic [2:0] IF_PROTOCOL_POS = 3'd7;

  localparam logic [7:0] CLASS_HID         = 8'd3;  // bInterfaceClass
  localparam logic [7:0] SUBCLASS_BOOT     = 8'd1;  // bInterfaceSubClass
  localparam logic [7:0] PROTOCOL_KEYBOARD = 8'd1;  // bInterfaceProtocol, 2 is mouse

endpackage

// File: verilog/usb_byte_if.sv
/*
 * received byte stream from line engine to report decoder
 *   byte strobe with data and payload index
 *   end of packet strobe and attach level
 */
`timescale 1ns/1ps

interface usb_byte_if;
  import usb_line_pkg::*;

  logic      byte_stb;   // one cycle, byte_data/byte_idx valid
  usb_byte_t byte_data;
  byte_idx_t byte_idx;   // payload position, sync/pid excluded
  logic      pkt_end;    // one cycle after SE0 sampled
  logic      connected;  // device attached

  modport source (
    output byte_stb,
    output byte_data,
    output byte_idx,
    output pkt_end,
    output connected
  );

  modport sink (
    input byte_stb,
    input byte_data,
    input byte_idx,
    input pkt_end,
    input connected
  );

endinterface

// File: verilog/usb_rx_phy.sv
/*
 * low-speed USB receive line engine
 *   D+/D- synchronizer and line state decode
 *   bit phase recovery from line transitions
 *   NRZI decode, unstuffing, LSB first byte assembly
 *   end of packet strobe, attach/detach detection
 */
`timescale 1ns/1ps

module usb_rx_phy #(
  parameter int CLKS_PER_BIT = 8,    // 1.5 Mbit/s at 12 MHz
  parameter int ATTACH_CLKS  = 256   // steady J/SE0 for attach/detach
) (
  input  logic       usbclk,
  input  logic       usbrst_n,
  input  logic       usb_dp_i,
  input  logic       usb_dm_i,
  usb_byte_if.source bytes
);
  import usb_line_pkg::*;

  localparam int PW = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int DW = (ATTACH_CLKS > 2) ? $clog2(ATTACH_CLKS) : 1;
  localparam logic [PW-1:0] HALF_LOAD = PW'(CLKS_PER_BIT / 2 - 1);  // mid-bit after edge
  localparam logic [PW-1:0] FULL_LOAD = PW'(CLKS_PER_BIT - 1);
  localparam logic [DW-1:0] DUR_MAX   = DW'(ATTACH_CLKS - 1);

  logic [1:0]    dp_sync;    // two-stage synchronizers
  logic [1:0]    dm_sync;
  line_state_e   cur_ls;     // synchronized line state
  line_state_e   prev_ls;    // state one clock ago
  line_state_e   last_smp;   // state at previous bit sample
  logic [PW-1:0] phase;      // clocks to next sample instant
  logic          line_chg;
  logic          smp_stb;
  logic          bit_ok;     // sample is a packet data bit
  logic          stuffed;    // sample is a stuffed zero
  logic          take_bit;
  logic          nrzi_bit;
  logic          in_pkt;
  logic [2:0]    ones_cnt;   // run of decoded ones
  logic [2:0]    bit_cnt;    // bits in current byte
  byte_cnt_t     byte_cnt;   // whole bytes in packet, saturating
  byte_cnt_t     pay_idx;
  logic          payload;    // current byte is delivered
  usb_byte_t     shreg;
  logic [DW-1:0] dur_cnt;    // clocks since last line change

  assign cur_ls   = line_state_e'({dp_sync[1], dm_sync[1]});
  assign line_chg = (cur_ls != prev_ls);
  assign smp_stb  = !line_chg && (phase == '0);  // an edge restarts the bit phase
  assign nrzi_bit = (cur_ls == last_smp);         // no transition is a one
  assign stuffed  = (ones_cnt == STUFF_LIMIT);
  assign bit_ok   = smp_stb && (cur_ls == LS_J || cur_ls == LS_K) &&
                    (in_pkt || (bytes.connected && cur_ls == LS_K));  // first K opens sync
  assign take_bit = bit_ok && !stuffed;
  assign pay_idx  = byte_cnt - HDR_BYTES;
  assign payload  = (byte_cnt >= HDR_BYTES) && (byte_cnt < HDR_BYTES + MAX_PAYLOAD);

  always_ff @(posedge usbclk) begin
    if (!usbrst_n) begin
      dp_sync        <= '0;
      dm_sync        <= '0;
      prev_ls        <= LS_SE0;
      last_smp       <= LS_J;
      phase          <= FULL_LOAD;
      in_pkt         <= 1'b0;
      ones_cnt       <= '0;
      bit_cnt        <= '0;
      byte_cnt       <= '0;
      bytes.byte_stb <= 1'b0;
      bytes.pkt_end  <= 1'b0;
    end else begin
      dp_sync        <= {dp_sync[0], usb_dp_i};
      dm_sync        <= {dm_sync[0], usb_dm_i};
      prev_ls        <= cur_ls;
      bytes.byte_stb <= 1'b0;  // strobes last one cycle
      bytes.pkt_end  <= 1'b0;

      if (line_chg) begin
        phase <= HALF_LOAD;
      end else if (phase == '0) begin
        phase <= FULL_LOAD;  // free run without edges
      end else begin
        phase <= phase - 1'b1;
      end

      if (smp_stb && cur_ls == LS_SE0) begin
        bytes.pkt_end <= in_pkt;  // only first SE0 sample of the packet
        in_pkt        <= 1'b0;
        ones_cnt      <= '0;
        bit_cnt       <= '0;
        byte_cnt      <= '0;
        last_smp      <= LS_J;    // EOP returns to idle J
      end else if (smp_stb && cur_ls != LS_SE1) begin
        last_smp <= cur_ls;
      end

      if (bit_ok) begin
        in_pkt <= 1'b1;
        if (stuffed) begin
          ones_cnt <= '0;  // stuffed zero, dropped
        end else begin
          ones_cnt <= nrzi_bit ? ones_cnt + 3'd1 : 3'd0;
          bit_cnt  <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            bytes.byte_stb <= payload;  // crc and extra bytes dropped
            if (byte_cnt != '1) begin
              byte_cnt <= byte_cnt + 4'd1;
            end
          end
        end
      end
    end
  end

  // data path, qualified by byte_stb
  always_ff @(posedge usbclk) begin
    if (take_bit) begin
      shreg <= {nrzi_bit, shreg[7:1]};  // LSB first
    end
    if (take_bit && bit_cnt == 3'd7) begin
      bytes.byte_data <= {nrzi_bit, shreg[7:1]};
      bytes.byte_idx  <= pay_idx[2:0];
    end
  end

  // attach after steady J, detach after steady SE0
  always_ff @(posedge usbclk) begin
    if (!usbrst_n) begin
      dur_cnt         <= '0;
      bytes.connected <= 1'b0;
    end else begin
      if (line_chg) begin
        dur_cnt <= '0;
      end else if (dur_cnt != DUR_MAX) begin
        dur_cnt <= dur_cnt + 1'b1;
      end
      if (dur_cnt == DUR_MAX && cur_ls == LS_J) begin
        bytes.connected <= 1'b1;
      end else if (dur_cnt == DUR_MAX && cur_ls == LS_SE0) begin
        bytes.connected <= 1'b0;
      end
    end
  end

  // data bits and EOP never share a sample
  a_stb_not_end: assert property (@(posedge usbclk) disable iff (!usbrst_n)
    !(bytes.byte_stb && bytes.pkt_end));

  // packets are only opened while attached
  a_stb_connected: assert property (@(posedge usbclk) disable iff (!usbrst_n)
    bytes.byte_stb |-> bytes.connected);

endmodule

// File: verilog/hid_report_decoder.sv
/*
 * HID report interpreter
 *   device type from interface descriptor class fields
 *   keyboard, mouse and gamepad report field decode
 *   report pulse, mouse motion clear, type clear on detach
 */
`timescale 1ns/1ps

module hid_report_decoder (
  input  logic                      usbclk,
  input  logic                      usbrst_n,
  input  logic                      desc_sel_i,  // current packets are descriptors
  usb_byte_if.sink                  bytes,
  output hid_report_pkg::hid_type_e typ_o,
  output logic                      report_o,
  output usb_line_pkg::usb_byte_t   key_mod_o,
  output usb_line_pkg::usb_byte_t   key1_o,
  output usb_line_pkg::usb_byte_t   key2_o,
  output usb_line_pkg::usb_byte_t   key3_o,
  output usb_line_pkg::usb_byte_t   key4_o,
  output usb_line_pkg::usb_byte_t   mouse_btn_o,
  output usb_line_pkg::usb_byte_t   mouse_dx_o,   // signed, zeroed after report
  output usb_line_pkg::usb_byte_t   mouse_dy_o,
  output hid_report_pkg::game_btn_t game_btn_o
);
  import usb_line_pkg::*;
  import hid_report_pkg::*;

  usb_byte_t if_class;     // captured descriptor fields
  usb_byte_t if_subclass;
  usb_byte_t if_protocol;
  hid_type_e desc_typ;
  usb_byte_t d;
  logic      rpt_stb;
  logic      desc_stb;
  logic      pad_valid;    // gamepad record not marked irrelevant

  // axis pair from a low/high extreme, else unchanged
  function automatic logic [1:0] axis_dir(input logic lo, input logic hi,
                                          input logic [1:0] keep);
    logic [1:0] res;
    res = keep;
    if (lo) begin
      res = 2'b01;  // left or up
    end else if (hi) begin
      res = 2'b10;  // right or down
    end
    return res;
  endfunction

  assign d        = bytes.byte_data;
  assign rpt_stb  = bytes.byte_stb && !desc_sel_i;
  assign desc_stb = bytes.byte_stb && desc_sel_i;

  always_comb begin
    if (if_class != CLASS_HID) begin
      desc_typ = HID_NONE;
    end else if (if_subclass != SUBCLASS_BOOT) begin
      desc_typ = HID_GAMEPAD;  // non-boot HID taken as gamepad
    end else if (if_protocol == PROTOCOL_KEYBOARD) begin
      desc_typ = HID_KEYBOARD;
    end else begin
      desc_typ = HID_MOUSE;
    end
  end

  always_ff @(posedge usbclk) begin
    if (!usbrst_n) begin
      typ_o       <= HID_NONE;
      report_o    <= 1'b0;
      if_class    <= '0;
      if_subclass <= '0;
      if_protocol <= '0;
    end else begin
      report_o <= bytes.pkt_end && !desc_sel_i && (typ_o != HID_NONE);
      if (!bytes.connected) begin
        typ_o <= HID_NONE;  // detached
      end else if (bytes.pkt_end && desc_sel_i) begin
        typ_o <= desc_typ;
      end
      if (desc_stb) begin
        case (bytes.byte_idx)
          IF_CLASS_POS:    if_class    <= d;
          IF_SUBCLASS_POS: if_subclass <= d;
          IF_PROTOCOL_POS: if_protocol <= d;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge usbclk) begin
    if (!usbrst_n) begin
      key_mod_o   <= '0;
      key1_o      <= '0;
      key2_o      <= '0;
      key3_o      <= '0;
      key4_o      <= '0;
      mouse_btn_o <= '0;
      mouse_dx_o  <= '0;
      mouse_dy_o  <= '0;
      game_btn_o  <= '0;
      pad_valid   <= 1'b0;
    end else begin
      if (report_o) begin
        mouse_dx_o <= '0;  // motion is relative
        mouse_dy_o <= '0;
      end
      if (rpt_stb && typ_o == HID_KEYBOARD) begin
        case (bytes.byte_idx)
          3'd0: key_mod_o <= d;
          3'd2: key1_o    <= d;  // byte 1 reserved
          3'd3: key2_o    <= d;
          3'd4: key3_o    <= d;
          3'd5: key4_o    <= d;
          default: ;
        endcase
      end
      if (rpt_stb && typ_o == HID_MOUSE) begin
        case (bytes.byte_idx)
          3'd0: mouse_btn_o <= d;
          3'd1: mouse_dx_o  <= d;
          3'd2: mouse_dy_o  <= d;
          default: ;
        endcase
      end
      if (rpt_stb && typ_o == HID_GAMEPAD) begin
        case (bytes.byte_idx)
          3'd0: begin
            pad_valid <= (d[1:0] != 2'b10);  // 2 marks an adapter side record
            if (d[1:0] != 2'b10) begin
              game_btn_o[GB_RIGHT:GB_LEFT] <= axis_dir(d == 8'h00, d == 8'hff, 2'b00);
              game_btn_o[GB_DOWN:GB_UP]    <= 2'b00;
            end
          end
          3'd1: game_btn_o[GB_DOWN:GB_UP] <=
                  axis_dir(d == 8'h00, d == 8'hff, game_btn_o[GB_DOWN:GB_UP]);
          3'd3: if (pad_valid) begin
            game_btn_o[GB_RIGHT:GB_LEFT] <=
              axis_dir(d[7:6] == 2'b00, d[7:6] == 2'b11, game_btn_o[GB_RIGHT:GB_LEFT]);
          end
          3'd4: if (pad_valid) begin
            game_btn_o[GB_DOWN:GB_UP] <=
              axis_dir(d[7:6] == 2'b00, d[7:6] == 2'b11, game_btn_o[GB_DOWN:GB_UP]);
          end
          3'd5: if (pad_valid) begin
            game_btn_o[GB_X] <= d[4];  // buttons YBAX in high nibble
            game_btn_o[GB_A] <= d[5];
            game_btn_o[GB_B] <= d[6];
            game_btn_o[GB_Y] <= d[7];
          end
          3'd6: if (pad_valid) begin
            game_btn_o[GB_SELECT] <= d[4];
            game_btn_o[GB_START]  <= d[5];
          end
          default: ;
        endcase
      end
    end
  end

  // pkt_end is a single strobe per packet
  a_report_pulse: assert property (@(posedge usbclk) disable iff (!usbrst_n)
    report_o |=> !report_o);

  // type reads none while detached, after the first cycle of detach
  a_type_detach: assert property (@(posedge usbclk) disable iff (!usbrst_n)
    !bytes.connected && !$fell(bytes.connected) |-> typ_o == HID_NONE);

endmodule

// File: verilog/usb_hid_rx.sv
/*
 * low-speed USB HID report receiver, top level
 *   byte stream interface instance
 *   line engine and report decoder instances
 */
`timescale 1ns/1ps

module usb_hid_rx #(
  parameter int CLKS_PER_BIT = 8,    // 12 MHz clock, 1.5 Mbit/s line
  parameter int ATTACH_CLKS  = 256
) (
  input  logic                      usbclk,
  input  logic                      usbrst_n,
  input  logic                      usb_dp_i,
  input  logic                      usb_dm_i,
  input  logic                      desc_sel_i,
  output logic                      connected_o,
  output hid_report_pkg::hid_type_e typ_o,
  output logic                      report_o,
  output usb_line_pkg::usb_byte_t   key_mod_o,
  output usb_line_pkg::usb_byte_t   key1_o,
  output usb_line_pkg::usb_byte_t   key2_o,
  output usb_line_pkg::usb_byte_t   key3_o,
  output usb_line_pkg::usb_byte_t   key4_o,
  output usb_line_pkg::usb_byte_t   mouse_btn_o,
  output usb_line_pkg::usb_byte_t   mouse_dx_o,
  output usb_line_pkg::usb_byte_t   mouse_dy_o,
  output hid_report_pkg::game_btn_t game_btn_o
);

  usb_byte_if u_bytes ();  // phy to decoder byte stream

  usb_rx_phy #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .ATTACH_CLKS  (ATTACH_CLKS)
  ) u_phy (
    .usbclk   (usbclk),
    .usbrst_n (usbrst_n),
    .usb_dp_i (usb_dp_i),
    .usb_dm_i (usb_dm_i),
    .bytes    (u_bytes.source)
  );

  hid_report_decoder u_dec (
    .usbclk      (usbclk),
    .usbrst_n    (usbrst_n),
    .desc_sel_i  (desc_sel_i),
    .bytes       (u_bytes.sink),
    .typ_o       (typ_o),
    .report_o    (report_o),
    .key_mod_o   (key_mod_o),
    .key1_o      (key1_o),
    .key2_o      (key2_o),
    .key3_o      (key3_o),
    .key4_o      (key4_o),
    .mouse_btn_o (mouse_btn_o),
    .mouse_dx_o  (mouse_dx_o),
    .mouse_dy_o  (mouse_dy_o),
    .game_btn_o  (game_btn_o)
  );

  assign connected_o = u_bytes.connected;  // attach level from phy

endmodule

// File: tests/tb_usb_hid_rx.sv
/*
 * testbench for the low-speed USB HID receiver
 *   stim file reader, NRZI packet encoder with bit stuffing
 *   report pulse monitor, field checks, watchdog
 */
`timescale 1ns/1ps

module tb_usb_hid_rx;
  import usb_line_pkg::*;
  import hid_report_pkg::*;

  localparam int CLKS_PER_BIT = 8;    // DUT defaults
  localparam int ATTACH_CLKS  = 256;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CLKS    = 20;   // J after each EOP
  localparam int STUFF_RUN    = 6;    // ones before a forced transition
  localparam int MAX_LINES    = 64;
  localparam int N_EXP        = 10;   // typ and nine report fields

  logic      usbclk;
  logic      usbrst_n;
  logic      usb_dp_i;
  logic      usb_dm_i;
  logic      desc_sel_i;
  logic      connected_o;
  hid_type_e typ_o;
  logic      report_o;
  usb_byte_t key_mod_o;
  usb_byte_t key1_o;
  usb_byte_t key2_o;
  usb_byte_t key3_o;
  usb_byte_t key4_o;
  usb_byte_t mouse_btn_o;
  usb_byte_t mouse_dx_o;
  usb_byte_t mouse_dy_o;
  game_btn_t game_btn_o;

  logic [7:0]  st_cmd  [MAX_LINES];         // A, D, S or R
  logic [7:0]  st_pid  [MAX_LINES];
  int          st_cnt  [MAX_LINES];
  logic [7:0]  st_data [MAX_LINES][10];
  logic [15:0] st_exp  [MAX_LINES][N_EXP];  // typ, mod, k1-k4, mbtn, dx, dy, gbtn
  int          n_lines    = 0;
  int          limit_clks = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  int          rpt_total  = 0;              // report_o pulses seen so far
  logic [15:0] cap [N_EXP];                 // outputs at the last pulse

  usb_hid_rx u_dut (
    .usbclk      (usbclk),
    .usbrst_n    (usbrst_n),
    .usb_dp_i    (usb_dp_i),
    .usb_dm_i    (usb_dm_i),
    .desc_sel_i  (desc_sel_i),
    .connected_o (connected_o),
    .typ_o       (typ_o),
    .report_o    (report_o),
    .key_mod_o   (key_mod_o),
    .key1_o      (key1_o),
    .key2_o      (key2_o),
    .key3_o      (key3_o),
    .key4_o      (key4_o),
    .mouse_btn_o (mouse_btn_o),
    .mouse_dx_o  (mouse_dx_o),
    .mouse_dy_o  (mouse_dy_o),
    .game_btn_o  (game_btn_o)
  );

  initial begin
    usbclk = 1'b0;
    forever #5 usbclk = ~usbclk;  // 10 ns period
  end

  function automatic logic [15:0] field_now(input int i);
    case (i)
      0: return 16'(typ_o);
      1: return 16'(key_mod_o);
      2: return 16'(key1_o);
      3: return 16'(key2_o);
      4: return 16'(key3_o);
      5: return 16'(key4_o);
      6: return 16'(mouse_btn_o);
      7: return 16'(mouse_dx_o);
      8: return 16'(mouse_dy_o);
      default: return 16'(game_btn_o);
    endcase
  endfunction

  function automatic string field_name(input int i);
    case (i)
      0: return "typ_o";
      1: return "key_mod_o";
      2: return "key1_o";
      3: return "key2_o";
      4: return "key3_o";
      5: return "key4_o";
      6: return "mouse_btn_o";
      7: return "mouse_dx_o";
      8: return "mouse_dy_o";
      default: return "game_btn_o";
    endcase
  endfunction

  // snapshot mid-cycle, dx/dy clear right after the pulse
  always @(negedge usbclk) begin
    if (report_o) begin
      rpt_total <= rpt_total + 1;
      for (int i = 0; i < N_EXP; i++) begin
        cap[i] <= field_now(i);
      end
    end
  end

  task automatic check_val(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
    assert (got == exp) else begin
      value_errs++;
      $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic hold_line(input logic dp, input logic dm, input int clks);
    @(posedge usbclk);
    #1;
    usb_dp_i = dp;
    usb_dm_i = dm;
    repeat (clks - 1) @(posedge usbclk);
  endtask

  // sync, pid, payload LSB first; NRZI with stuffing, then EOP and idle J
  task automatic send_packet(input int ln);
    logic [7:0] b;
    logic       lvl;   // D+ level, low is J
    int         ones;
    lvl  = 1'b0;
    ones = 0;
    for (int k = 0; k < st_cnt[ln] + 2; k++) begin
      b = (k == 0) ? 8'h80 : (k == 1) ? st_pid[ln] : st_data[ln][k-2];
      for (int j = 0; j < 8; j++) begin
        if (b[j]) begin
          ones++;
        end else begin
          lvl  = ~lvl;  // zero toggles the line
          ones = 0;
        end
        hold_line(lvl, ~lvl, CLKS_PER_BIT);
        if (ones == STUFF_RUN) begin
          lvl  = ~lvl;  // stuffed zero
          ones = 0;
          hold_line(lvl, ~lvl, CLKS_PER_BIT);
        end
      end
    end
    hold_line(1'b0, 1'b0, 2 * CLKS_PER_BIT);  // SE0
    hold_line(1'b0, 1'b1, IDLE_CLKS);
  endtask

  task automatic wait_connected(input logic level, input int ln);
    int waited;
    waited = 0;
    while (connected_o !== level && waited < ATTACH_CLKS + 64) begin
      @(negedge usbclk);
      waited++;
    end
    assert (connected_o === level) else begin
      other_errs++;
      $display("connected_o never reached %0b on stim line %0d", level, ln);
    end
  endtask

  task automatic wait_report(input int base, input int ln);
    int waited;
    waited = 0;
    while (rpt_total == base && waited < 64) begin
      @(negedge usbclk);
      waited++;
    end
    assert (rpt_total != base) else begin
      other_errs++;
      $display("no report_o pulse after the packet on stim line %0d", ln);
    end
  endtask

  task automatic load_stim();
    int    fd;
    int    n;
    string line;
    fd = $fopen("tests/hid_stim.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("cannot open tests/hid_stim.txt");
    end else begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 2 && line[0] != "#") begin
          n = $sscanf(line,
                "%s %h %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                st_cmd[n_lines], st_pid[n_lines], st_cnt[n_lines],
                st_data[n_lines][0], st_data[n_lines][1], st_data[n_lines][2],
                st_data[n_lines][3], st_data[n_lines][4], st_data[n_lines][5],
                st_data[n_lines][6], st_data[n_lines][7], st_data[n_lines][8],
                st_data[n_lines][9], st_exp[n_lines][0], st_exp[n_lines][1],
                st_exp[n_lines][2], st_exp[n_lines][3], st_exp[n_lines][4],
                st_exp[n_lines][5], st_exp[n_lines][6], st_exp[n_lines][7],
                st_exp[n_lines][8], st_exp[n_lines][9]);
          if (n == 23) begin
            n_lines++;
          end else begin
            other_errs++;
            $display("malformed stim line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    if (n_lines == 0) begin
      other_errs++;
      $display("stim file holds no commands");
    end
  endtask

  task automatic run_line(input int ln);
    int base;
    base = rpt_total;
    case (st_cmd[ln])
      "A": begin
        hold_line(1'b0, 1'b1, 1);  // idle J
        wait_connected(1'b1, ln);
        check_val("typ_o", 16'(typ_o), st_exp[ln][0]);
      end
      "D": begin
        hold_line(1'b0, 1'b0, 1);  // steady SE0
        wait_connected(1'b0, ln);
        repeat (2) @(negedge usbclk);
        check_val("typ_o", 16'(typ_o), st_exp[ln][0]);
      end
      "S": begin
        @(posedge usbclk);
        #1;
        desc_sel_i = 1'b1;
        send_packet(ln);
        check_val("report_o pulses", 16'(rpt_total - base), 16'h0);
        check_val("typ_o", 16'(typ_o), st_exp[ln][0]);
        @(posedge usbclk);
        #1;
        desc_sel_i = 1'b0;
      end
      "R": begin
        send_packet(ln);
        if (st_exp[ln][0] != 16'h0) begin
          wait_report(base, ln);
          repeat (2) @(negedge usbclk);
          check_val("report_o pulses", 16'(rpt_total - base), 16'h1);
          for (int i = 0; i < N_EXP; i++) begin
            check_val(field_name(i), cap[i], st_exp[ln][i]);
          end
          check_val("mouse_dx_o", 16'(mouse_dx_o), 16'h0);  // cleared after pulse
          check_val("mouse_dy_o", 16'(mouse_dy_o), 16'h0);
        end else begin
          check_val("report_o pulses", 16'(rpt_total - base), 16'h0);
          for (int i = 0; i < N_EXP; i++) begin
            check_val(field_name(i), field_now(i), st_exp[ln][i]);
          end
        end
      end
      default: begin
        other_errs++;
        $display("unknown command on stim line %0d", ln);
      end
    endcase
  endtask

  initial begin
    int total_bits;
    int n_att;
    usbrst_n   = 1'b0;
    usb_dp_i   = 1'b0;  // SE0, nothing attached
    usb_dm_i   = 1'b0;
    desc_sel_i = 1'b0;
    total_bits = 0;
    n_att      = 0;
    load_stim();
    for (int ln = 0; ln < n_lines; ln++) begin
      if (st_cmd[ln] == "A" || st_cmd[ln] == "D") begin
        n_att++;
      end else begin
        total_bits += (st_cnt[ln] + 2) * 8 + 2;  // bytes plus EOP
      end
    end
    limit_clks = total_bits * CLKS_PER_BIT * 2 + n_att * ATTACH_CLKS * 2 +
                 RESET_CYCLES + 100;
    repeat (RESET_CYCLES) @(posedge usbclk);
    #1;
    usbrst_n = 1'b1;
    for (int ln = 0; ln < n_lines; ln++) begin
      run_line(ln);
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog, sized once the stim file is read
  initial begin
    wait (limit_clks > 0);
    repeat (limit_clks) @(posedge usbclk);
    $display("watchdog expired after %0d cycles, stimulus did not complete", limit_clks);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: tests/hid_stim.txt
# cmd pid count b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 | expected typ mod k1 k2 k3 k4 mbtn dx dy gbtn
# A attach, D detach, S descriptor packet, R report packet; all hex except count
A 00 0  00 00 00 00 00 00 00 00 00 00  0 00 00 00 00 00 00 00 00 000
S C3 9  09 04 00 00 01 03 01 01 00 00  1 00 00 00 00 00 00 00 00 000
R 4B 8  02 55 04 05 06 07 00 00 00 00  1 02 04 05 06 07 00 00 00 000
R C3 10 FF FF 7F FF 7F 7F 00 00 A5 5A  1 FF 7F FF 7F 7F 00 00 00 000
S 4B 9  09 04 00 00 01 03 01 02 00 00  2 FF 7F FF 7F 7F 00 00 00 000
R C3 3  01 10 F0 00 00 00 00 00 00 00  2 FF 7F FF 7F 7F 01 10 F0 000
R 4B 4  05 FF 7F 01 00 00 00 00 00 00  2 FF 7F FF 7F 7F 05 FF 7F 000
S C3 9  09 04 00 00 02 03 00 00 00 00  3 FF 7F FF 7F 7F 05 00 00 000
R 4B 8  00 FF 00 80 40 50 10 00 00 00  3 FF 7F FF 7F 7F 05 00 00 169
R C3 8  01 7F 00 C0 00 A0 20 00 00 00  3 FF 7F FF 7F 7F 05 00 00 296
R 4B 8  02 FF 00 00 C0 F0 30 00 00 00  3 FF 7F FF 7F 7F 05 00 00 29A
R C3 10 FF 00 FF C0 FF FF FF 7F FF FF  3 FF 7F FF 7F 7F 05 00 00 3FA
D 00 0  00 00 00 00 00 00 00 00 00 00  0 FF 7F FF 7F 7F 05 00 00 3FA
R 4B 6  11 00 22 33 44 55 00 00 00 00  0 FF 7F FF 7F 7F 05 00 00 3FA
A 00 0  00 00 00 00 00 00 00 00 00 00  0 FF 7F FF 7F 7F 05 00 00 3FA
S C3 9  09 04 00 00 02 08 06 50 00 00  0 FF 7F FF 7F 7F 05 00 00 3FA
R 4B 3  01 02 03 00 00 00 00 00 00 00  0 FF 7F FF 7F 7F 05 00 00 3FA
S C3 9  09 04 00 00 01 03 01 01 00 00  1 FF 7F FF 7F 7F 05 00 00 3FA
R 4B 6  00 00 1E 1F 20 21 00 00 00 00  1 00 1E 1F 20 21 05 00 00 3FA

// File: usb_hid_rx.f
verilog/usb_line_pkg.sv
verilog/hid_report_pkg.sv
verilog/usb_byte_if.sv
verilog/usb_rx_phy.sv
verilog/hid_report_decoder.sv
verilog/usb_hid_rx.sv
tests/tb_usb_hid_rx.sv

// File: Makefile
# Verilator build and run of the usb_hid_rx testbench
SIM      ?= verilator
FLAGS    ?= --binary --assert -Wno-fatal
TOP      ?= tb_usb_hid_rx
FILELIST ?= usb_hid_rx.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
